// ==== compile.f ====
+incdir+src
src/rv_pkg.sv
src/pipe_reg.sv
src/fetch_unit.sv
src/reg_file.sv
src/decoder.sv
src/execute_unit.sv
src/mem_access.sv
src/hazard_unit.sv
src/core_top.sv
verification/core_properties.sv
verification/core_tb.sv

// ==== Makefile ====
SIM      := verilator
TOP      := core_tb
FILELIST := compile.f
FLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verification/core_tb.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module core_tb;

   localparam int NPROG       = 8;
   localparam int NUM_RAND    = 40;
   localparam int PROG_LEN    = NUM_RAND + 9;
   localparam int ROM_WORDS   = 64;
   localparam int RAM_WORDS   = 1 << `RV_RAM_ADDR_W;
   localparam int AREA_ADDR   = 'h100;
   localparam int RESULT_ADDR = 'h140;
   localparam int DONE_ADDR   = 'h180;
   localparam int CYCLE_LIMIT = NPROG * PROG_LEN * 3 + 100;

   typedef enum int {
      K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT,
      K_ADDI, K_LW, K_SW, K_BEQ, K_BNE, K_JAL
   } kind_e;

   logic                      clk = 1'b0;
   logic                      rstn;
   logic [`RV_XLEN-1:0]       rom_addr;
   logic [`RV_XLEN-1:0]       rom_data;
   logic [`RV_RAM_ADDR_W-1:0] ram_addr;
   logic                      ram_en;
   logic                      ram_we;
   logic [`RV_XLEN-1:0]       ram_wdata;
   logic [`RV_XLEN-1:0]       ram_rdata;

   logic [`RV_XLEN-1:0]       rom [ROM_WORDS];
   logic [`RV_XLEN-1:0]       ram [RAM_WORDS];
   logic [`RV_XLEN-1:0]       model_mem [RAM_WORDS];
   logic [`RV_XLEN-1:0]       read_q;
   kind_e                     kind_f [PROG_LEN];
   int                        rd_f [PROG_LEN];
   int                        rs1_f [PROG_LEN];
   int                        rs2_f [PROG_LEN];
   int                        imm_f [PROG_LEN];
   logic [`RV_RAM_ADDR_W-1:0] exp_addr [$];
   logic [`RV_XLEN-1:0]       exp_data [$];
   integer                    seed;
   int                        errors;
   int                        checks;
   int                        stores;
   int                        cycles;
   int                        cur_prog;
   logic                      done;

   core_top DUT (
      .clk(clk), .rstn(rstn), .rom_addr(rom_addr), .rom_data(rom_data),
      .ram_addr(ram_addr), .ram_en(ram_en), .ram_we(ram_we),
      .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
   );

   always #50 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // checks and helpers

   task automatic check(input logic [`RV_XLEN-1:0] expected,
                        input logic [`RV_XLEN-1:0] actual, input string what);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAIL %0t: %s, expected %h, got %h", $time, what, expected, actual);
      end
   endtask

   function automatic int pick(input int n);
      return {$random(seed)} % n;
   endfunction

   function automatic logic [`RV_XLEN-1:0] fill_word(input int a);
      return 32'h5A00_0000 ^ (a << 12) ^ a;
   endfunction

   function automatic string mode_name(input int mode);
      case (mode)
         0:       return "alu";
         1:       return "forwarding";
         2:       return "load/store";
         default: return "branch";
      endcase
   endfunction

   function automatic logic [31:0] encode(input kind_e k, input int rd, input int rs1,
                                          input int rs2, input int imm);
      logic [4:0]  d;
      logic [4:0]  s1;
      logic [4:0]  s2;
      logic [31:0] im;
      logic [31:0] w;
      d  = 5'(rd);
      s1 = 5'(rs1);
      s2 = 5'(rs2);
      im = imm;
      case (k)
         K_ADD:   w = {7'h00, s2, s1, 3'b000, d, 7'b0110011};
         K_SUB:   w = {7'h20, s2, s1, 3'b000, d, 7'b0110011};
         K_AND:   w = {7'h00, s2, s1, 3'b111, d, 7'b0110011};
         K_OR:    w = {7'h00, s2, s1, 3'b110, d, 7'b0110011};
         K_XOR:   w = {7'h00, s2, s1, 3'b100, d, 7'b0110011};
         K_SLT:   w = {7'h00, s2, s1, 3'b010, d, 7'b0110011};
         K_ADDI:  w = {im[11:0], s1, 3'b000, d, 7'b0010011};
         K_LW:    w = {im[11:0], s1, 3'b010, d, 7'b0000011};
         K_SW:    w = {im[11:5], s2, s1, 3'b010, im[4:0], 7'b0100011};
         K_BEQ:   w = {im[12], im[10:5], s2, s1, 3'b000, im[4:1], im[11], 7'b1100011};
         K_BNE:   w = {im[12], im[10:5], s2, s1, 3'b001, im[4:1], im[11], 7'b1100011};
         K_JAL:   w = {im[20], im[10:1], im[11], im[19:12], d, 7'b1101111};
         default: w = '0;
      endcase
      return w;
   endfunction

   task automatic put_instr(input int idx, input kind_e k, input int rd, input int rs1,
                            input int rs2, input int imm);
      kind_f[idx] = k;
      rd_f[idx]   = rd;
      rs1_f[idx]  = rs1;
      rs2_f[idx]  = rs2;
      imm_f[idx]  = imm;
      rom[idx]    = encode(k, rd, rs1, rs2, imm);
   endtask

   //////////////////////////////////////////////////////////////////////
   // program generator and ISA model

   task automatic gen_program(input int mode);
      kind_e k;
      int    i;
      int    rd;
      int    rs1;
      int    rs2;
      int    imm;
      int    span;
      int    last_rd;
      int    prev_rd;
      last_rd = 0;
      prev_rd = 0;
      for (i = 0; i < ROM_WORDS; i++) begin
         rom[i] = '0;
      end
      for (i = 0; i < NUM_RAND; i++) begin
         case (mode)
            0, 1:    k = kind_e'(pick(7));
            2:       k = kind_e'(pick(9));
            default: k = kind_e'(pick(12));
         endcase
         rd  = pick(8);
         rs1 = pick(8);
         rs2 = pick(8);
         imm = 0;
         // chained operands hit both forwarding paths
         if (mode == 1) begin
            rs1 = last_rd;
            rs2 = prev_rd;
         end
         case (k)
            K_ADDI: imm = pick(4096) - 2048;
            K_LW, K_SW: begin
               rs1 = 0;
               imm = AREA_ADDR + 4 * pick(16);
            end
            K_BEQ, K_BNE, K_JAL: begin
               // forward only, never past the epilogue
               span = 1 + pick(4);
               if (span > NUM_RAND - i) begin
                  span = NUM_RAND - i;
               end
               imm = 4 * span;
            end
            default: ;
         endcase
         prev_rd = last_rd;
         last_rd = rd;
         put_instr(i, k, rd, rs1, rs2, imm);
      end
      // epilogue stores x1 to x7, then the done word, then spins
      for (i = 1; i < 8; i++) begin
         put_instr(NUM_RAND + i - 1, K_SW, 0, 0, i, RESULT_ADDR + 4 * (i - 1));
      end
      put_instr(NUM_RAND + 7, K_SW, 0, 0, 0, DONE_ADDR);
      put_instr(NUM_RAND + 8, K_JAL, 0, 0, 0, 0);
   endtask

   task automatic run_model();
      logic [`RV_XLEN-1:0] xr [8];
      logic [`RV_XLEN-1:0] a;
      logic [`RV_XLEN-1:0] b;
      logic [`RV_XLEN-1:0] r;
      logic [`RV_XLEN-1:0] ea;
      logic                wr;
      int                  i;
      int                  next;
      for (i = 0; i < 8; i++) begin
         xr[i] = '0;
      end
      i = 0;
      while (i < PROG_LEN && !(kind_f[i] == K_JAL && imm_f[i] == 0)) begin
         a    = xr[rs1_f[i]];
         b    = xr[rs2_f[i]];
         ea   = a + imm_f[i];
         r    = '0;
         wr   = 1'b1;
         next = i + 1;
         case (kind_f[i])
            K_ADD:  r = a + b;
            K_SUB:  r = a - b;
            K_AND:  r = a & b;
            K_OR:   r = a | b;
            K_XOR:  r = a ^ b;
            K_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_ADDI: r = ea;
            K_LW:   r = model_mem[ea[`RV_RAM_ADDR_W+1:2]];
            K_SW: begin
               wr = 1'b0;
               model_mem[ea[`RV_RAM_ADDR_W+1:2]] = b;
               exp_addr.push_back(ea[`RV_RAM_ADDR_W+1:2]);
               exp_data.push_back(b);
            end
            K_BEQ: begin
               wr = 1'b0;
               if (a == b) next = i + imm_f[i] / 4;
            end
            K_BNE: begin
               wr = 1'b0;
               if (a != b) next = i + imm_f[i] / 4;
            end
            default: begin
               r    = `RV_RESET_PC + 4 * (i + 1);
               next = i + imm_f[i] / 4;
            end
         endcase
         if (wr && rd_f[i] != 0) begin
            xr[rd_f[i]] = r;
         end
         i = next;
      end
   endtask

   task automatic prepare_test(input int mode);
      int a;
      gen_program(mode);
      for (a = 0; a < RAM_WORDS; a++) begin
         ram[a]       = fill_word(a);
         model_mem[a] = fill_word(a);
      end
      exp_addr.delete();
      exp_data.delete();
      stores = 0;
      done   = 1'b0;
      run_model();
   endtask

   task automatic match_store(input logic [`RV_RAM_ADDR_W-1:0] waddr,
                              input logic [`RV_XLEN-1:0] wdata);
      if (exp_addr.size() == 0) begin
         errors++;
         $display("store to word %0d at %0t ns, but the model has no store left", waddr, $time);
      end else begin
         check(exp_addr.pop_front(), waddr, "store address");
         check(exp_data.pop_front(), wdata, "store data");
         stores++;
      end
      if (waddr == DONE_ADDR / 4) begin
         done = 1'b1;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // ROM and RAM models, driven on the falling edge

   always @(negedge clk) begin
      rom_data  = rom[rom_addr[7:2]];
      // read data of the previous cycle's request
      ram_rdata = read_q;
      if (ram_en && !ram_we) begin
         read_q = ram[ram_addr];
      end
      if (ram_en && ram_we) begin
         ram[ram_addr] = ram_wdata;
         match_store(ram_addr, ram_wdata);
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > CYCLE_LIMIT) begin
         $display("run timed out after %0d cycles, program %0d never stored its done word",
                  CYCLE_LIMIT, cur_prog);
         $display("Test failed");
         $finish;
      end
   end

   initial begin
      int p;
      int c;
      int err_before;
      seed      = 32'h1660;
      rstn      = 1'b1;
      rom_data  = '0;
      ram_rdata = '0;
      read_q    = '0;
      done      = 1'b0;
      errors    = 0;
      checks    = 0;
      stores    = 0;
      cycles    = 0;
      cur_prog  = 0;
      for (p = 0; p < NPROG; p++) begin
         cur_prog   = p;
         err_before = errors;
         rstn       = 1'b1;
         for (c = 0; c < 3; c++) begin
            @(negedge clk);
            if (c == 0) begin
               prepare_test(p % 4);
            end
            check(0, ram_we, "ram_we during reset");
            check(`RV_RESET_PC, rom_addr, "rom_addr during reset");
         end
         rstn = 1'b0;
         wait (done);
         check(0, exp_addr.size(), "model stores missing on the RAM port");
         $display("test %0d (%s): %0d stores matched, %0d errors",
                  p, mode_name(p % 4), stores, errors - err_before);
      end
      $display("%0d tests, %0d checks, %0d errors", NPROG, checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== verification/core_properties.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module core_properties (
   input logic                clk,
   input logic                rstn,
   input logic [`RV_XLEN-1:0] rom_addr,
   input logic                ram_en,
   input logic                ram_we
);

   // fetch restarts at the reset vector
   fetch_from_reset_pc: assert property (@(posedge clk) rstn |=> rom_addr == `RV_RESET_PC)
      else $error("rom_addr is not the reset PC in the cycle after reset");

   fetch_aligned: assert property (@(posedge clk) disable iff (rstn) rom_addr[1:0] == 2'b00)
      else $error("rom_addr is not word aligned");

   quiet_after_reset: assert property (@(posedge clk) rstn |=> !ram_en && !ram_we)
      else $error("RAM access in the cycle after reset");

endmodule

bind core_top core_properties u_props (
   .clk(clk), .rstn(rstn), .rom_addr(rom_addr), .ram_en(ram_en), .ram_we(ram_we)
);

// ==== src/core_top.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module core_top (
   input  logic                      clk,
   input  logic                      rstn,
   output logic [`RV_XLEN-1:0]       rom_addr,
   input  logic [`RV_XLEN-1:0]       rom_data,
   output logic [`RV_RAM_ADDR_W-1:0] ram_addr,
   output logic                      ram_en,
   output logic                      ram_we,
   output logic [`RV_XLEN-1:0]       ram_wdata,
   input  logic [`RV_XLEN-1:0]       ram_rdata
);

   rv_pkg::fd_t               fetch_out;
   rv_pkg::fd_t               fd_q;
   rv_pkg::de_t               de_d;
   rv_pkg::de_t               de_q;
   rv_pkg::em_t               em_d;
   rv_pkg::em_t               em_q;
   rv_pkg::mw_t               mw_d;
   rv_pkg::mw_t               mw_q;
   logic                      fd_valid;
   logic                      de_valid;
   logic                      em_valid;
   logic                      mw_valid;
   logic [`RV_REG_ADDR_W-1:0] rs1;
   logic [`RV_REG_ADDR_W-1:0] rs2;
   logic [`RV_XLEN-1:0]       rs1_val;
   logic [`RV_XLEN-1:0]       rs2_val;
   logic                      need_rs1;
   logic                      need_rs2;
   logic                      take_jump;
   logic [`RV_XLEN-1:0]       jump_target;
   logic [`RV_XLEN-1:0]       wb_data;
   logic                      stall;
   logic                      flush;

   //////////////////////////////////////////////////////////////////////
   // fetch and decode

   fetch_unit u_fetch (
      .clk(clk), .rstn(rstn), .stall(stall), .take_jump(flush),
      .jump_target(jump_target), .rom_addr(rom_addr), .rom_data(rom_data),
      .fetch_out(fetch_out)
   );

   pipe_reg #(.payload_t(rv_pkg::fd_t)) pipe_fd (
      .clk(clk), .rstn(rstn), .hold(stall), .flush(flush),
      .valid_in(1'b1), .data_in(fetch_out), .valid_out(fd_valid), .data_out(fd_q)
   );

   decoder u_decoder (
      .fd_in(fd_q), .fd_valid(fd_valid), .rs1(rs1), .rs2(rs2),
      .rs1_val(rs1_val), .rs2_val(rs2_val),
      .em_fwd(em_d), .em_fwd_valid(de_valid), .mw_fwd(mw_d), .mw_fwd_valid(em_valid),
      .de_out(de_d), .need_rs1(need_rs1), .need_rs2(need_rs2)
   );

   reg_file u_regs (
      .clk(clk), .rstn(rstn), .rs1(rs1), .rs2(rs2), .rs1_val(rs1_val), .rs2_val(rs2_val),
      .wr_en(mw_valid && mw_q.writes_rd), .wr_addr(mw_q.rd), .wr_data(wb_data)
   );

   // a stall turns the decode slot into a bubble
   pipe_reg #(.payload_t(rv_pkg::de_t)) pipe_de (
      .clk(clk), .rstn(rstn), .hold(1'b0), .flush(flush || stall),
      .valid_in(fd_valid), .data_in(de_d), .valid_out(de_valid), .data_out(de_q)
   );

   //////////////////////////////////////////////////////////////////////
   // execute, memory, writeback

   execute_unit u_exec (
      .de_in(de_q), .de_valid(de_valid), .em_out(em_d),
      .take_jump(take_jump), .jump_target(jump_target)
   );

   pipe_reg #(.payload_t(rv_pkg::em_t)) pipe_em (
      .clk(clk), .rstn(rstn), .hold(1'b0), .flush(1'b0),
      .valid_in(de_valid), .data_in(em_d), .valid_out(em_valid), .data_out(em_q)
   );

   mem_access u_mem (
      .clk(clk), .rstn(rstn), .em_in(em_q), .em_valid(em_valid),
      .ram_addr(ram_addr), .ram_en(ram_en), .ram_we(ram_we),
      .ram_wdata(ram_wdata), .ram_rdata(ram_rdata), .mw_out(mw_d), .wb_data(wb_data)
   );

   pipe_reg #(.payload_t(rv_pkg::mw_t)) pipe_mw (
      .clk(clk), .rstn(rstn), .hold(1'b0), .flush(1'b0),
      .valid_in(em_valid), .data_in(mw_d), .valid_out(mw_valid), .data_out(mw_q)
   );

   hazard_unit u_hazard (
      .fd_rs1(rs1), .fd_rs2(rs2), .need_rs1(need_rs1), .need_rs2(need_rs2),
      .de_instr(de_q.dec), .de_valid(de_valid), .em_instr(em_q.dec), .em_valid(em_valid),
      .take_jump(take_jump), .stall(stall), .flush(flush)
   );

endmodule

// ==== src/hazard_unit.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module hazard_unit (
   input  logic [`RV_REG_ADDR_W-1:0] fd_rs1,
   input  logic [`RV_REG_ADDR_W-1:0] fd_rs2,
   input  logic                      need_rs1,
   input  logic                      need_rs2,
   input  rv_pkg::dec_instr_t        de_instr,
   input  logic                      de_valid,
   input  rv_pkg::dec_instr_t        em_instr,
   input  logic                      em_valid,
   input  logic                      take_jump,
   output logic                      stall,
   output logic                      flush
);

   logic de_hit;
   logic em_hit;

   function automatic logic load_use(
      input rv_pkg::dec_instr_t        ld,
      input logic                      ld_valid,
      input logic [`RV_REG_ADDR_W-1:0] r1,
      input logic [`RV_REG_ADDR_W-1:0] r2,
      input logic                      n1,
      input logic                      n2
   );
      return ld_valid && ld.is_load && ld.rd != '0
             && ((n1 && r1 == ld.rd) || (n2 && r2 == ld.rd));
   endfunction

   // loaded word is only seen at writeback
   assign de_hit = load_use(de_instr, de_valid, fd_rs1, fd_rs2, need_rs1, need_rs2);
   assign em_hit = load_use(em_instr, em_valid, fd_rs1, fd_rs2, need_rs1, need_rs2);

   // the waiting instruction is discarded anyway on a redirect
   assign flush = take_jump;
   assign stall = !take_jump && (de_hit || em_hit);

endmodule

// ==== src/mem_access.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module mem_access (
   input  logic                      clk,
   input  logic                      rstn,
   input  rv_pkg::em_t               em_in,
   input  logic                      em_valid,
   output logic [`RV_RAM_ADDR_W-1:0] ram_addr,
   output logic                      ram_en,
   output logic                      ram_we,
   output logic [`RV_XLEN-1:0]       ram_wdata,
   input  logic [`RV_XLEN-1:0]       ram_rdata,
   output rv_pkg::mw_t               mw_out,
   output logic [`RV_XLEN-1:0]       wb_data
);

   logic                load_q;
   logic [`RV_XLEN-1:0] result_q;

   // word address from the byte address
   assign ram_addr  = em_in.result[`RV_RAM_ADDR_W+1:2];
   assign ram_en    = em_valid && (em_in.dec.is_load || em_in.dec.is_store);
   assign ram_we    = em_valid && em_in.dec.is_store;
   assign ram_wdata = em_in.store_data;

   assign mw_out.rd        = em_in.dec.rd;
   assign mw_out.writes_rd = em_in.dec.writes_rd;
   assign mw_out.is_load   = em_in.dec.is_load;
   assign mw_out.result    = em_in.result;

   always_ff @(posedge clk) begin
      if (rstn) begin
         load_q <= 1'b0;
      end else begin
         load_q <= em_valid && em_in.dec.is_load;
      end
   end

   always_ff @(posedge clk) begin
      result_q <= em_in.result;
   end

   // read data lands in the writeback cycle
   assign wb_data = load_q ? ram_rdata : result_q;

endmodule

// ==== src/execute_unit.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module execute_unit (
   input  rv_pkg::de_t         de_in,
   input  logic                de_valid,
   output rv_pkg::em_t         em_out,
   output logic                take_jump,
   output logic [`RV_XLEN-1:0] jump_target
);

   logic [`RV_XLEN-1:0] a;
   logic [`RV_XLEN-1:0] b;
   logic [`RV_XLEN-1:0] result;
   logic                cond;

   assign a = de_in.rs1_val;
   assign b = de_in.rs2_val;

   always_comb begin
      result = a + de_in.dec.imm;
      case (de_in.dec.op)
         rv_pkg::op_add: result = a + b;
         rv_pkg::op_sub: result = a - b;
         rv_pkg::op_and: result = a & b;
         rv_pkg::op_or:  result = a | b;
         rv_pkg::op_xor: result = a ^ b;
         rv_pkg::op_slt: result = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
         // link value
         rv_pkg::op_jal: result = de_in.pc + `RV_XLEN'd4;
         default: ;
      endcase
   end

   // beq and bne differ only in the sense of the compare
   assign cond = (de_in.dec.op == rv_pkg::op_bne) ? (a != b) : (a == b);

   assign take_jump   = de_valid && (de_in.dec.is_jump || (de_in.dec.is_branch && cond));
   assign jump_target = de_in.pc + de_in.dec.imm;

   assign em_out.dec        = de_in.dec;
   assign em_out.result     = result;
   assign em_out.store_data = b;

endmodule

// ==== src/decoder.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module decoder (
   input  rv_pkg::fd_t               fd_in,
   input  logic                      fd_valid,
   output logic [`RV_REG_ADDR_W-1:0] rs1,
   output logic [`RV_REG_ADDR_W-1:0] rs2,
   input  logic [`RV_XLEN-1:0]       rs1_val,
   input  logic [`RV_XLEN-1:0]       rs2_val,
   input  rv_pkg::em_t               em_fwd,
   input  logic                      em_fwd_valid,
   input  rv_pkg::mw_t               mw_fwd,
   input  logic                      mw_fwd_valid,
   output rv_pkg::de_t               de_out,
   output logic                      need_rs1,
   output logic                      need_rs2
);

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;

   logic [`RV_XLEN-1:0] ins;
   logic [`RV_XLEN-1:0] imm_i;
   logic [`RV_XLEN-1:0] imm_s;
   logic [`RV_XLEN-1:0] imm_b;
   logic [`RV_XLEN-1:0] imm_j;
   rv_pkg::dec_instr_t  dec;
   logic                em_wr;
   logic                mw_wr;

   assign ins   = fd_in.instr;
   assign imm_i = {{20{ins[31]}}, ins[31:20]};
   assign imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
   assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
   assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

   always_comb begin
      dec     = '0;
      dec.op  = rv_pkg::op_nop;
      dec.rd  = ins[11:7];
      dec.rs1 = ins[19:15];
      dec.rs2 = ins[24:20];
      case (ins[6:0])
         OPC_OP: begin
            dec.uses_rs1  = 1'b1;
            dec.uses_rs2  = 1'b1;
            dec.writes_rd = 1'b1;
            case ({ins[31:25], ins[14:12]})
               {7'h00, 3'b000}: dec.op = rv_pkg::op_add;
               {7'h20, 3'b000}: dec.op = rv_pkg::op_sub;
               {7'h00, 3'b111}: dec.op = rv_pkg::op_and;
               {7'h00, 3'b110}: dec.op = rv_pkg::op_or;
               {7'h00, 3'b100}: dec.op = rv_pkg::op_xor;
               {7'h00, 3'b010}: dec.op = rv_pkg::op_slt;
               default: begin
                  dec.uses_rs1  = 1'b0;
                  dec.uses_rs2  = 1'b0;
                  dec.writes_rd = 1'b0;
               end
            endcase
         end
         OPC_OP_IMM: begin
            if (ins[14:12] == 3'b000) begin
               dec.op        = rv_pkg::op_addi;
               dec.imm       = imm_i;
               dec.uses_rs1  = 1'b1;
               dec.writes_rd = 1'b1;
            end
         end
         OPC_LOAD: begin
            if (ins[14:12] == 3'b010) begin
               dec.op        = rv_pkg::op_lw;
               dec.imm       = imm_i;
               dec.uses_rs1  = 1'b1;
               dec.writes_rd = 1'b1;
               dec.is_load   = 1'b1;
            end
         end
         OPC_STORE: begin
            if (ins[14:12] == 3'b010) begin
               dec.op       = rv_pkg::op_sw;
               dec.imm      = imm_s;
               dec.uses_rs1 = 1'b1;
               dec.uses_rs2 = 1'b1;
               dec.is_store = 1'b1;
            end
         end
         OPC_BRANCH: begin
            if (ins[14:13] == 2'b00) begin
               dec.op        = ins[12] ? rv_pkg::op_bne : rv_pkg::op_beq;
               dec.imm       = imm_b;
               dec.uses_rs1  = 1'b1;
               dec.uses_rs2  = 1'b1;
               dec.is_branch = 1'b1;
            end
         end
         OPC_JAL: begin
            dec.op        = rv_pkg::op_jal;
            dec.imm       = imm_j;
            dec.writes_rd = 1'b1;
            dec.is_jump   = 1'b1;
         end
         default: ;
      endcase
   end

   assign rs1      = dec.rs1;
   assign rs2      = dec.rs2;
   assign need_rs1 = fd_valid && dec.uses_rs1;
   assign need_rs2 = fd_valid && dec.uses_rs2;

   //////////////////////////////////////////////////////////////////////
   // operand forwarding

   // one step ahead, straight from the ALU
   assign em_wr = em_fwd_valid && em_fwd.dec.writes_rd && em_fwd.dec.rd != '0;
   // two steps ahead, loads are left to the stall
   assign mw_wr = mw_fwd_valid && mw_fwd.writes_rd && !mw_fwd.is_load && mw_fwd.rd != '0;

   assign de_out.dec     = dec;
   assign de_out.pc      = fd_in.pc;
   assign de_out.rs1_val = (em_wr && em_fwd.dec.rd == rs1) ? em_fwd.result
                         : (mw_wr && mw_fwd.rd == rs1)     ? mw_fwd.result
                         : rs1_val;
   assign de_out.rs2_val = (em_wr && em_fwd.dec.rd == rs2) ? em_fwd.result
                         : (mw_wr && mw_fwd.rd == rs2)     ? mw_fwd.result
                         : rs2_val;

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module reg_file (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic [`RV_REG_ADDR_W-1:0] rs1,
   input  logic [`RV_REG_ADDR_W-1:0] rs2,
   output logic [`RV_XLEN-1:0]       rs1_val,
   output logic [`RV_XLEN-1:0]       rs2_val,
   input  logic                      wr_en,
   input  logic [`RV_REG_ADDR_W-1:0] wr_addr,
   input  logic [`RV_XLEN-1:0]       wr_data
);

   localparam int NREGS = 1 << `RV_REG_ADDR_W;

   logic [`RV_XLEN-1:0] regs [NREGS];

   always_ff @(posedge clk) begin
      if (rstn) begin
         for (int i = 0; i < NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && wr_addr != '0) begin
         regs[wr_addr] <= wr_data;
      end
   end

   // write-through covers the writeback stage
   assign rs1_val = (rs1 == '0) ? '0 : (wr_en && wr_addr == rs1) ? wr_data : regs[rs1];
   assign rs2_val = (rs2 == '0) ? '0 : (wr_en && wr_addr == rs2) ? wr_data : regs[rs2];

endmodule

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module fetch_unit (
   input  logic                clk,
   input  logic                rstn,
   input  logic                stall,
   input  logic                take_jump,
   input  logic [`RV_XLEN-1:0] jump_target,
   output logic [`RV_XLEN-1:0] rom_addr,
   input  logic [`RV_XLEN-1:0] rom_data,
   output rv_pkg::fd_t         fetch_out
);

   logic [`RV_XLEN-1:0] pc;

   // redirect wins over a load-use hold
   always_ff @(posedge clk) begin
      if (rstn) begin
         pc <= `RV_RESET_PC;
      end else if (take_jump) begin
         pc <= jump_target;
      end else if (!stall) begin
         pc <= pc + `RV_XLEN'd4;
      end
   end

   assign rom_addr        = pc;
   assign fetch_out.pc    = pc;
   assign fetch_out.instr = rom_data;

endmodule

// ==== src/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rstn,
   input  logic     hold,
   input  logic     flush,
   input  logic     valid_in,
   input  payload_t data_in,
   output logic     valid_out,
   output payload_t data_out
);

   // flush beats hold and leaves a bubble
   always_ff @(posedge clk) begin
      if (rstn) begin
         valid_out <= 1'b0;
      end else if (flush) begin
         valid_out <= 1'b0;
      end else if (!hold) begin
         valid_out <= valid_in;
      end
   end

   always_ff @(posedge clk) begin
      if (!hold) begin
         data_out <= data_in;
      end
   end

endmodule

// ==== src/rv_pkg.sv ====
`include "rv_config.svh"

package rv_pkg;

   // kept RV32I operations
   typedef enum logic [3:0] {
      op_nop,
      op_add,
      op_sub,
      op_and,
      op_or,
      op_xor,
      op_slt,
      op_addi,
      op_lw,
      op_sw,
      op_beq,
      op_bne,
      op_jal
   } alu_op_e;

   typedef struct packed {
      alu_op_e                   op;
      logic [`RV_REG_ADDR_W-1:0] rd;
      logic [`RV_REG_ADDR_W-1:0] rs1;
      logic [`RV_REG_ADDR_W-1:0] rs2;
      logic [`RV_XLEN-1:0]       imm;
      logic                      uses_rs1;
      logic                      uses_rs2;
      logic                      writes_rd;
      logic                      is_load;
      logic                      is_store;
      logic                      is_branch;
      logic                      is_jump;
   } dec_instr_t;

   //////////////////////////////////////////////////////////////////////
   // stage payloads

   typedef struct packed {
      logic [`RV_XLEN-1:0] pc;
      logic [`RV_XLEN-1:0] instr;
   } fd_t;

   typedef struct packed {
      dec_instr_t          dec;
      logic [`RV_XLEN-1:0] pc;
      logic [`RV_XLEN-1:0] rs1_val;
      logic [`RV_XLEN-1:0] rs2_val;
   } de_t;

   // result is the load/store address for memory ops
   typedef struct packed {
      dec_instr_t          dec;
      logic [`RV_XLEN-1:0] result;
      logic [`RV_XLEN-1:0] store_data;
   } em_t;

   typedef struct packed {
      logic [`RV_REG_ADDR_W-1:0] rd;
      logic                      writes_rd;
      logic                      is_load;
      logic [`RV_XLEN-1:0]       result;
   } mw_t;

endpackage

// ==== src/rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// integer datapath width
`define RV_XLEN 32

// x0 to x31
`define RV_REG_ADDR_W 5

// data RAM word address, 4 KiB
`define RV_RAM_ADDR_W 10

`define RV_RESET_PC 32'h0000_0000

`endif
